// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int NB_DATA      = 32;
    localparam int NB_REG       = 5;
    localparam int NB_MEM_WIDTH = 8;

    // Primary opcodes, MIPS32 encoding
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0a,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // R-type function field
    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_NOR  = 6'h27,
        F_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    alu_src_imm;
        logic    reg_dest_rd;
        logic    zero_ext;
        logic    branch;
        logic    branch_ne;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic               valid;
        logic [NB_DATA-1:0] pc_plus4;
        logic [NB_DATA-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic               valid;
        ctrl_t              ctrl;
        logic [NB_DATA-1:0] pc_plus4;
        logic [NB_DATA-1:0] data_a;
        logic [NB_DATA-1:0] data_b;
        logic [NB_DATA-1:0] imm;
        logic [NB_REG-1:0]  shamt;
        logic [NB_REG-1:0]  rt;
        logic [NB_REG-1:0]  rd;
    } id_ex_t;

    typedef struct packed {
        logic               valid;
        ctrl_t              ctrl;
        logic [NB_DATA-1:0] branch_addr;
        logic               zero;
        logic [NB_DATA-1:0] alu_result;
        logic [NB_DATA-1:0] data_b;
        logic [NB_REG-1:0]  dest;
    } ex_mem_t;

    typedef struct packed {
        logic               valid;
        logic               reg_write;
        logic               mem_to_reg;
        logic [NB_DATA-1:0] mem_data;
        logic [NB_DATA-1:0] alu_result;
        logic [NB_REG-1:0]  dest;
    } mem_wb_t;

endpackage

`default_nettype wire

// File: instr_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module instr_fetch import cpu_pkg::*; #(
    parameter int IMEM_DEPTH = 64
) (
    input  wire                     i_clock,
    input  wire                     i_rst_n,
    input  wire                     i_pc_enable,
    input  wire                     i_write_enable,
    input  wire [NB_MEM_WIDTH-1:0]  i_write_data,
    input  wire                     i_jump,
    input  wire [NB_DATA-1:0]       i_jump_addr,
    input  wire                     i_branch_taken,
    input  wire [NB_DATA-1:0]       i_branch_addr,
    output if_id_t                  o_if_id
);

    localparam int NB_LOAD = $clog2(IMEM_DEPTH * 4);

    logic [NB_DATA-1:0]      pc;
    logic [NB_DATA-1:0]      pc_plus4;
    logic [NB_LOAD-1:0]      load_ptr;
    logic [NB_LOAD-3:0]      fetch_word;
    logic [NB_MEM_WIDTH-1:0] imem [IMEM_DEPTH][4];

    assign pc_plus4   = pc + NB_DATA'(4);
    assign fetch_word = pc[NB_LOAD-1:2];

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc       <= '0;
            load_ptr <= '0;
        end else begin
            // Branch from MEM wins over jump from ID
            if (i_branch_taken)
                pc <= i_branch_addr;
            else if (i_jump)
                pc <= i_jump_addr;
            else if (i_pc_enable)
                pc <= pc_plus4;
            if (i_write_enable)
                load_ptr <= load_ptr + 1'b1;
        end
    end

    // Byte loads from the debug port
    always_ff @(posedge i_clock) begin
        if (i_write_enable)
            imem[load_ptr[NB_LOAD-1:2]][load_ptr[1:0]] <= i_write_data;
    end

    // Big-endian word assembly
    always_comb begin
        o_if_id.valid    = i_pc_enable & ~i_jump & ~i_branch_taken;
        o_if_id.pc_plus4 = pc_plus4;
        o_if_id.instr    = {imem[fetch_word][0], imem[fetch_word][1],
                            imem[fetch_word][2], imem[fetch_word][3]};
    end

endmodule

`default_nettype wire

// File: control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit import cpu_pkg::*; (
    input  wire [NB_DATA-1:0] i_instr,
    output ctrl_t             o_ctrl,
    output logic              o_jump
);

    opcode_e opcode;
    funct_e  funct;

    assign opcode = opcode_e'(i_instr[31:26]);
    assign funct  = funct_e'(i_instr[5:0]);

    always_comb begin
        o_ctrl = '0;
        o_jump = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.reg_dest_rd = 1'b1;
                case (funct)
                    F_ADDU:  o_ctrl.alu_op = ALU_ADD;
                    F_SUBU:  o_ctrl.alu_op = ALU_SUB;
                    F_AND:   o_ctrl.alu_op = ALU_AND;
                    F_OR:    o_ctrl.alu_op = ALU_OR;
                    F_XOR:   o_ctrl.alu_op = ALU_XOR;
                    F_NOR:   o_ctrl.alu_op = ALU_NOR;
                    F_SLT:   o_ctrl.alu_op = ALU_SLT;
                    F_SLL:   o_ctrl.alu_op = ALU_SLL;
                    F_SRL:   o_ctrl.alu_op = ALU_SRL;
                    // unsupported function behaves as nop
                    default: o_ctrl = '0;
                endcase
            end
            OP_ADDIU, OP_SLTI, OP_LUI: begin
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.alu_op      = (opcode == OP_ADDIU) ? ALU_ADD :
                                     (opcode == OP_SLTI)  ? ALU_SLT : ALU_LUI;
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.zero_ext    = 1'b1;
                o_ctrl.alu_op      = (opcode == OP_ANDI) ? ALU_AND :
                                     (opcode == OP_ORI)  ? ALU_OR  : ALU_XOR;
            end
            OP_LW: begin
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.mem_read    = 1'b1;
                o_ctrl.mem_to_reg  = 1'b1;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.alu_op      = ALU_ADD;
            end
            OP_SW: begin
                o_ctrl.mem_write   = 1'b1;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.alu_op      = ALU_ADD;
            end
            OP_BEQ, OP_BNE: begin
                o_ctrl.branch    = 1'b1;
                o_ctrl.branch_ne = (opcode == OP_BNE);
                o_ctrl.alu_op    = ALU_SUB;
            end
            OP_J:    o_jump = 1'b1;
            default: o_ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  wire                i_clock,
    input  wire                i_rst_n,
    input  wire [NB_REG-1:0]   i_rs,
    input  wire [NB_REG-1:0]   i_rt,
    input  wire                i_we,
    input  wire [NB_REG-1:0]   i_wr_reg,
    input  wire [NB_DATA-1:0]  i_wr_data,
    output logic [NB_DATA-1:0] o_data_a,
    output logic [NB_DATA-1:0] o_data_b
);

    logic [NB_DATA-1:0] regs [2**NB_REG];

    // r0 is hardwired, a write in the same cycle is seen by the reader
    function automatic logic [NB_DATA-1:0] read_port(input logic [NB_REG-1:0] idx);
        if (idx == '0)
            return '0;
        if (i_we && (idx == i_wr_reg))
            return i_wr_data;
        return regs[idx];
    endfunction

    always_comb begin
        o_data_a = read_port(i_rs);
        o_data_b = read_port(i_rt);
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 2**NB_REG; i++)
                regs[i] <= '0;
        end else if (i_we && (i_wr_reg != '0)) begin
            regs[i_wr_reg] <= i_wr_data;
        end
    end

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
    input  alu_op_e            i_op,
    input  wire [NB_DATA-1:0]  i_a,
    input  wire [NB_DATA-1:0]  i_b,
    input  wire [NB_REG-1:0]   i_shamt,
    output logic [NB_DATA-1:0] o_result,
    output logic               o_zero
);

    localparam int NB_HALF = NB_DATA / 2;

    always_comb begin
        case (i_op)
            ALU_ADD: o_result = i_a + i_b;
            ALU_SUB: o_result = i_a - i_b;
            ALU_AND: o_result = i_a & i_b;
            ALU_OR:  o_result = i_a | i_b;
            ALU_XOR: o_result = i_a ^ i_b;
            ALU_NOR: o_result = ~(i_a | i_b);
            ALU_SLT: o_result = NB_DATA'($signed(i_a) < $signed(i_b));
            // Shifts act on the rt operand
            ALU_SLL: o_result = i_b << i_shamt;
            ALU_SRL: o_result = i_b >> i_shamt;
            ALU_LUI: o_result = {i_b[NB_HALF-1:0], {NB_HALF{1'b0}}};
            default: o_result = '0;
        endcase
    end

    // Branch compare uses SUB
    assign o_zero = (o_result == '0);

endmodule

`default_nettype wire

// File: data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem import cpu_pkg::*; #(
    parameter int DMEM_DEPTH = 64
) (
    input  wire                i_clock,
    input  wire                i_write,
    input  wire [NB_DATA-1:0]  i_addr,
    input  wire [NB_DATA-1:0]  i_wdata,
    output logic [NB_DATA-1:0] o_rdata
);

    localparam int NB_IDX = $clog2(DMEM_DEPTH);

    logic [NB_DATA-1:0] mem [DMEM_DEPTH];
    logic [NB_IDX-1:0]  word_idx;

    // Word aligned, byte offset ignored
    assign word_idx = i_addr[NB_IDX+1:2];
    assign o_rdata  = mem[word_idx];

    always_ff @(posedge i_clock) begin
        if (i_write)
            mem[word_idx] <= i_wdata;
    end

endmodule

`default_nettype wire

// File: mips_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module mips_pipeline import cpu_pkg::*; #(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 64
) (
    input  wire                     i_clock,
    input  wire                     i_rst_n,
    input  wire                     i_write_enable,
    input  wire [NB_MEM_WIDTH-1:0]  i_write_data,
    input  wire                     i_pc_enable,
    output logic                    o_wb_we,
    output logic [NB_REG-1:0]       o_wb_reg,
    output logic [NB_DATA-1:0]      o_wb_data
);

    if_id_t  if_d,  if_id;
    id_ex_t  id_d,  id_ex;
    ex_mem_t ex_d,  ex_mem;
    mem_wb_t mem_d, mem_wb;

    // ID stage
    ctrl_t              id_ctrl;
    logic               id_jump_raw;
    logic               id_jump;
    logic [NB_DATA-1:0] id_jump_addr;
    logic [15:0]        id_imm16;
    logic [NB_DATA-1:0] id_data_a;
    logic [NB_DATA-1:0] id_data_b;

    // EX and MEM stages
    logic [NB_DATA-1:0] ex_alu_b;
    logic [NB_DATA-1:0] ex_alu_result;
    logic               ex_zero;
    logic               branch_taken;
    logic [NB_DATA-1:0] mem_rdata;

    instr_fetch #(.IMEM_DEPTH(IMEM_DEPTH)) instr_fetch_1 (
        .i_clock        (i_clock),
        .i_rst_n        (i_rst_n),
        .i_pc_enable    (i_pc_enable),
        .i_write_enable (i_write_enable),
        .i_write_data   (i_write_data),
        .i_jump         (id_jump),
        .i_jump_addr    (id_jump_addr),
        .i_branch_taken (branch_taken),
        .i_branch_addr  (ex_mem.branch_addr),
        .o_if_id        (if_d)
    );

    control_unit control_unit_1 (
        .i_instr (if_id.instr),
        .o_ctrl  (id_ctrl),
        .o_jump  (id_jump_raw)
    );

    reg_file reg_file_1 (
        .i_clock   (i_clock),
        .i_rst_n   (i_rst_n),
        .i_rs      (if_id.instr[25:21]),
        .i_rt      (if_id.instr[20:16]),
        .i_we      (o_wb_we),
        .i_wr_reg  (o_wb_reg),
        .i_wr_data (o_wb_data),
        .o_data_a  (id_data_a),
        .o_data_b  (id_data_b)
    );

    alu alu_1 (
        .i_op     (id_ex.ctrl.alu_op),
        .i_a      (id_ex.data_a),
        .i_b      (ex_alu_b),
        .i_shamt  (id_ex.shamt),
        .o_result (ex_alu_result),
        .o_zero   (ex_zero)
    );

    data_mem #(.DMEM_DEPTH(DMEM_DEPTH)) data_mem_1 (
        .i_clock (i_clock),
        .i_write (ex_mem.valid & ex_mem.ctrl.mem_write),
        .i_addr  (ex_mem.alu_result),
        .i_wdata (ex_mem.data_b),
        .o_rdata (mem_rdata)
    );

    // Jump resolves in ID, target is in the 256 MB region of pc+4
    assign id_jump      = if_id.valid & id_jump_raw;
    assign id_jump_addr = {if_id.pc_plus4[31:28], if_id.instr[25:0], 2'b00};
    assign id_imm16     = if_id.instr[15:0];

    // Branch resolves in MEM and flushes the three younger stages
    assign branch_taken = ex_mem.valid & ex_mem.ctrl.branch &
                          (ex_mem.ctrl.branch_ne ? ~ex_mem.zero : ex_mem.zero);

    assign ex_alu_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : id_ex.data_b;

    always_comb begin
        id_d.valid    = if_id.valid & ~branch_taken;
        id_d.ctrl     = id_ctrl;
        id_d.pc_plus4 = if_id.pc_plus4;
        id_d.data_a   = id_data_a;
        id_d.data_b   = id_data_b;
        id_d.imm      = id_ctrl.zero_ext ? {16'h0000, id_imm16} : {{16{id_imm16[15]}}, id_imm16};
        id_d.shamt    = if_id.instr[10:6];
        id_d.rt       = if_id.instr[20:16];
        id_d.rd       = if_id.instr[15:11];

        ex_d.valid       = id_ex.valid & ~branch_taken;
        ex_d.ctrl        = id_ex.ctrl;
        ex_d.branch_addr = id_ex.pc_plus4 + {id_ex.imm[NB_DATA-3:0], 2'b00};
        ex_d.zero        = ex_zero;
        ex_d.alu_result  = ex_alu_result;
        ex_d.data_b      = id_ex.data_b;
        ex_d.dest        = id_ex.ctrl.reg_dest_rd ? id_ex.rd : id_ex.rt;

        mem_d.valid      = ex_mem.valid;
        mem_d.reg_write  = ex_mem.ctrl.reg_write;
        mem_d.mem_to_reg = ex_mem.ctrl.mem_to_reg;
        mem_d.mem_data   = ex_mem.ctrl.mem_read ? mem_rdata : '0;
        mem_d.alu_result = ex_mem.alu_result;
        mem_d.dest       = ex_mem.dest;
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            if_id  <= '0;
            id_ex  <= '0;
            ex_mem <= '0;
            mem_wb <= '0;
        end else begin
            if_id  <= if_d;
            id_ex  <= id_d;
            ex_mem <= ex_d;
            mem_wb <= mem_d;
        end
    end

    // Writeback
    assign o_wb_we   = mem_wb.valid & mem_wb.reg_write & (mem_wb.dest != '0);
    assign o_wb_reg  = mem_wb.dest;
    assign o_wb_data = mem_wb.mem_to_reg ? mem_wb.mem_data : mem_wb.alu_result;

endmodule

`default_nettype wire

// File: tb_isa_model.svh
// Instruction encoders
function automatic logic [31:0] enc_r(input funct_e fn, input int rd, input int rs,
                                      input int rt, input int sh);
    return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
endfunction

// Operand order follows the assembler form op rt, rs, imm
function automatic logic [31:0] enc_i(input opcode_e op, input int rt, input int rs,
                                      input logic [15:0] imm);
    return {op, rs[4:0], rt[4:0], imm};
endfunction

function automatic logic [31:0] enc_j(input int word_idx);
    return {OP_J, word_idx[25:0]};
endfunction

// Sequential model of the kept subset, no delay slots
// Stops at a jump to itself and fills exp_reg and exp_data in program order
function automatic void run_model();
    logic [31:0] regs [32];
    logic [31:0] dmem [64];
    logic [31:0] pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] simm;
    logic [31:0] addr;
    logic [31:0] res;
    logic [31:0] next_pc;
    logic [4:0]  dest;
    logic        wr;
    exp_reg.delete();
    exp_data.delete();
    foreach (regs[i])
        regs[i] = '0;
    pc = '0;
    for (int step = 0; step < 256; step++) begin
        ins     = prog[pc[7:2]];
        a       = regs[ins[25:21]];
        b       = regs[ins[20:16]];
        simm    = {{16{ins[15]}}, ins[15:0]};
        addr    = a + simm;
        next_pc = pc + 32'd4;
        dest    = ins[20:16];
        wr      = 1'b1;
        res     = '0;
        case (ins[31:26])
            OP_RTYPE: begin
                dest = ins[15:11];
                case (ins[5:0])
                    F_ADDU:  res = a + b;
                    F_SUBU:  res = a - b;
                    F_AND:   res = a & b;
                    F_OR:    res = a | b;
                    F_XOR:   res = a ^ b;
                    F_NOR:   res = ~(a | b);
                    F_SLT:   res = {31'b0, $signed(a) < $signed(b)};
                    F_SLL:   res = b << ins[10:6];
                    F_SRL:   res = b >> ins[10:6];
                    default: wr = 1'b0;
                endcase
            end
            OP_ADDIU: res = a + simm;
            OP_SLTI:  res = {31'b0, $signed(a) < $signed(simm)};
            OP_ANDI:  res = a & {16'h0000, ins[15:0]};
            OP_ORI:   res = a | {16'h0000, ins[15:0]};
            OP_XORI:  res = a ^ {16'h0000, ins[15:0]};
            OP_LUI:   res = {ins[15:0], 16'h0000};
            OP_LW:    res = dmem[addr[7:2]];
            OP_SW: begin
                dmem[addr[7:2]] = b;
                wr = 1'b0;
            end
            OP_BEQ, OP_BNE: begin
                wr = 1'b0;
                if ((a == b) == (ins[31:26] == OP_BEQ))
                    next_pc = pc + 32'd4 + (simm << 2);
            end
            OP_J: begin
                wr = 1'b0;
                next_pc = {next_pc[31:28], ins[25:0], 2'b00};
            end
            default: wr = 1'b0;
        endcase
        if (wr && dest != 5'd0) begin
            regs[dest] = res;
            exp_reg.push_back(dest);
            exp_data.push_back(res);
        end
        if (next_pc == pc)
            break;
        pc = next_pc;
    end
endfunction

// File: tb_mips_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_pipeline import cpu_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int WAIT_CYCLES  = 40;
    localparam int QUIET_CYCLES = 20;

    logic                    i_clock;
    logic                    i_rst_n;
    logic                    i_write_enable;
    logic [NB_MEM_WIDTH-1:0] i_write_data;
    logic                    i_pc_enable;
    logic                    o_wb_we;
    logic [NB_REG-1:0]       o_wb_reg;
    logic [NB_DATA-1:0]      o_wb_data;

    logic [31:0] prog [64];
    int          prog_len;
    logic [4:0]  exp_reg [$];
    logic [31:0] exp_data [$];
    logic [31:0] rng_state;
    int          errors;
    int          checks;

    `include "tb_isa_model.svh"

    mips_pipeline #(.IMEM_DEPTH(64), .DMEM_DEPTH(64)) dut_i (
        .i_clock        (i_clock),
        .i_rst_n        (i_rst_n),
        .i_write_enable (i_write_enable),
        .i_write_data   (i_write_data),
        .i_pc_enable    (i_pc_enable),
        .o_wb_we        (o_wb_we),
        .o_wb_reg       (o_wb_reg),
        .o_wb_data      (o_wb_data)
    );

    always #(CLK_PERIOD / 2) i_clock = ~i_clock;

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    task automatic add_instr(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    task automatic add_nops(input int count);
        repeat (count) add_instr(32'h0000_0000);
    endtask

    // Closing jump to itself, then one nop for the squashed fetch
    task automatic close_program();
        add_instr(enc_j(prog_len));
        add_instr(32'h0000_0000);
    endtask

    task automatic reset_dut();
        @(negedge i_clock);
        i_rst_n        = 1'b0;
        i_write_enable = 1'b0;
        i_write_data   = '0;
        i_pc_enable    = 1'b0;
        repeat (2) @(negedge i_clock);
        i_rst_n = 1'b1;
    endtask

    // Big-endian byte order, bits 31 to 24 first
    task automatic load_program();
        for (int w = 0; w < prog_len; w++) begin
            for (int k = 3; k >= 0; k--) begin
                @(negedge i_clock);
                i_write_enable = 1'b1;
                i_write_data   = prog[w][8*k +: 8];
            end
        end
        @(negedge i_clock);
        i_write_enable = 1'b0;
    endtask

    task automatic run_and_check(input string name);
        logic seen;
        logic quiet;
        run_model();
        @(negedge i_clock);
        i_pc_enable = 1'b1;
        for (int n = 0; n < exp_reg.size(); n++) begin
            seen = 1'b0;
            for (int t = 0; t < WAIT_CYCLES && !seen; t++) begin
                @(negedge i_clock);
                seen = o_wb_we;
            end
            if (!seen) begin
                $display("%s: register write %0d of %0d did not appear within %0d cycles",
                         name, n + 1, exp_reg.size(), WAIT_CYCLES);
                errors++;
                i_pc_enable = 1'b0;
                return;
            end
            checks++;
            if (o_wb_reg !== exp_reg[n] || o_wb_data !== exp_data[n]) begin
                $display("** Error at %0t: %s write %0d gave r%0d = %h, expected r%0d = %h",
                         $time, name, n + 1, o_wb_reg, o_wb_data, exp_reg[n], exp_data[n]);
                errors++;
            end
        end
        // Program now spins on its closing jump
        quiet = 1'b1;
        for (int t = 0; t < QUIET_CYCLES && quiet; t++) begin
            @(negedge i_clock);
            if (o_wb_we) begin
                $display("** Error at %0t: %s extra write r%0d = %h after the last one",
                         $time, name, o_wb_reg, o_wb_data);
                errors++;
                quiet = 1'b0;
            end
        end
        checks++;
        i_pc_enable = 1'b0;
    endtask

    task automatic test_idle_and_r0();
        logic [31:0] r;
        r = next_random();
        reset_dut();
        for (int t = 0; t < 20; t++) begin
            @(negedge i_clock);
            checks++;
            if (o_wb_we !== 1'b0) begin
                $display("** Error at %0t: o_wb_we is %b while the PC is disabled",
                         $time, o_wb_we);
                errors++;
            end
        end
        prog_len = 0;
        add_instr(enc_i(OP_ADDIU, 1, 0, r[15:0]));
        add_nops(3);
        add_instr(enc_r(F_ADDU, 0, 1, 1, 0));
        add_instr(enc_i(OP_ORI, 0, 1, 16'h5a5a));
        add_instr(enc_r(F_SLL, 0, 0, 1, 3));
        add_instr(enc_i(OP_ADDIU, 2, 0, r[31:16]));
        close_program();
        load_program();
        run_and_check("r0 writes");
    endtask

    task automatic test_rtype();
        logic [31:0] x;
        logic [31:0] y;
        x = next_random();
        y = next_random();
        reset_dut();
        prog_len = 0;
        add_instr(enc_i(OP_LUI, 1, 0, x[31:16]));
        add_instr(enc_i(OP_LUI, 2, 0, y[31:16]));
        add_nops(2);
        add_instr(enc_i(OP_ORI, 1, 1, x[15:0]));
        add_instr(enc_i(OP_ORI, 2, 2, y[15:0]));
        add_nops(3);
        add_instr(enc_r(F_ADDU, 3, 1, 2, 0));
        add_instr(enc_r(F_SUBU, 4, 1, 2, 0));
        add_instr(enc_r(F_AND, 5, 1, 2, 0));
        add_instr(enc_r(F_OR, 6, 1, 2, 0));
        add_instr(enc_r(F_XOR, 7, 1, 2, 0));
        add_instr(enc_r(F_NOR, 8, 1, 2, 0));
        add_instr(enc_r(F_SLT, 9, 1, 2, 0));
        add_instr(enc_r(F_SLT, 10, 2, 1, 0));
        add_instr(enc_r(F_SLL, 11, 0, 1, x[4:0]));
        add_instr(enc_r(F_SRL, 12, 0, 2, y[9:5]));
        close_program();
        load_program();
        run_and_check("rtype");
    endtask

    task automatic test_immediate();
        logic [31:0] r;
        logic [31:0] s;
        r = next_random();
        s = next_random();
        reset_dut();
        prog_len = 0;
        add_instr(enc_i(OP_ADDIU, 1, 0, 16'h8001));
        add_instr(enc_i(OP_ADDIU, 6, 0, 16'hf0f0));
        add_instr(enc_i(OP_SLTI, 3, 0, 16'hffff));
        add_instr(enc_i(OP_SLTI, 4, 0, 16'h0001));
        add_instr(enc_i(OP_LUI, 10, 0, r[15:0]));
        add_instr(enc_i(OP_ANDI, 7, 6, 16'h8f0f));
        add_instr(enc_i(OP_ORI, 8, 6, r[31:16]));
        add_instr(enc_i(OP_XORI, 9, 6, s[15:0]));
        add_instr(enc_i(OP_SLTI, 11, 6, s[31:16]));
        add_instr(enc_i(OP_ADDIU, 12, 1, r[23:8]));
        close_program();
        load_program();
        run_and_check("immediate");
    endtask

    task automatic test_load_store();
        logic [31:0] r;
        logic [31:0] s;
        r = next_random();
        s = next_random();
        reset_dut();
        prog_len = 0;
        add_instr(enc_i(OP_ADDIU, 1, 0, 16'h0010));
        add_instr(enc_i(OP_LUI, 2, 0, r[31:16]));
        add_instr(enc_i(OP_ADDIU, 3, 0, s[15:0]));
        add_nops(2);
        add_instr(enc_i(OP_ORI, 2, 2, r[15:0]));
        add_nops(3);
        add_instr(enc_i(OP_SW, 2, 1, 16'h0008));
        add_instr(enc_i(OP_SW, 3, 1, 16'h000c));
        add_instr(enc_i(OP_LW, 4, 1, 16'h0008));
        add_instr(enc_i(OP_LW, 5, 1, 16'h000c));
        close_program();
        load_program();
        run_and_check("load store");
    endtask

    task automatic test_branch();
        reset_dut();
        prog_len = 0;
        add_instr(enc_i(OP_ADDIU, 1, 0, 16'h0005));
        add_instr(enc_i(OP_ADDIU, 2, 0, 16'h0005));
        add_instr(enc_i(OP_ADDIU, 3, 0, 16'h0007));
        add_nops(3);
        // bne on equal operands falls through
        add_instr(enc_i(OP_BNE, 2, 1, 16'h0003));
        add_instr(enc_i(OP_ADDIU, 4, 0, 16'h0001));
        add_instr(enc_i(OP_BEQ, 2, 1, 16'h0003));
        add_instr(enc_i(OP_ADDIU, 5, 0, 16'h0002));
        add_instr(enc_i(OP_ADDIU, 6, 0, 16'h0003));
        add_instr(enc_i(OP_ADDIU, 7, 0, 16'h0004));
        add_instr(enc_i(OP_ADDIU, 8, 0, 16'h0005));
        add_instr(enc_r(F_ADDU, 9, 1, 3, 0));
        close_program();
        load_program();
        run_and_check("branch");
    endtask

    task automatic test_jump();
        logic [31:0] r;
        r = next_random();
        reset_dut();
        prog_len = 0;
        add_instr(enc_i(OP_ADDIU, 1, 0, r[15:0]));
        add_instr(enc_j(4));
        add_instr(enc_i(OP_ADDIU, 2, 0, 16'h0111));
        add_instr(enc_i(OP_ADDIU, 3, 0, 16'h0222));
        add_instr(enc_i(OP_ADDIU, 4, 0, r[31:16]));
        add_instr(enc_r(F_ADDU, 5, 1, 1, 0));
        close_program();
        load_program();
        run_and_check("jump");
    endtask

    initial begin
        i_clock        = 1'b0;
        i_rst_n        = 1'b0;
        i_write_enable = 1'b0;
        i_write_data   = '0;
        i_pc_enable    = 1'b0;
        rng_state      = 32'heb0a;
        errors         = 0;
        checks         = 0;
        prog_len       = 0;

        test_idle_and_r0();
        test_rtype();
        test_immediate();
        test_load_store();
        test_branch();
        test_jump();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+.
cpu_pkg.sv
instr_fetch.sv
control_unit.sv
reg_file.sv
alu.sv
data_mem.sv
mips_pipeline.sv
tb_mips_pipeline.sv
